// ==== verilog/instrTable.svh ====
// One line per RV32I instruction, expanded by Controller with its own INSTR macro
// Columns: key {funct7, funct3, opcode}, index, aluOp, aSel, bSel, ldExt,
//          memRead, memWrite, regWrite, memToReg, branch, jump
// Stores reuse ldExt for the access width

// Upper immediates and jumps
`INSTR({7'h00, 3'h0, OpLui   },  1, AluPassB, 0, 1, 3'h0, 0, 0, 1, 0, 0, 0)  // LUI
`INSTR({7'h00, 3'h0, OpAuipc },  2, AluAdd,   1, 1, 3'h0, 0, 0, 1, 0, 0, 0)  // AUIPC
`INSTR({7'h00, 3'h0, OpJ     },  3, AluAdd,   1, 1, 3'h0, 0, 0, 1, 0, 0, 1)  // JAL
`INSTR({7'h00, 3'h0, OpIJump },  4, AluAdd,   0, 1, 3'h0, 0, 0, 1, 0, 0, 1)  // JALR

// Branches compare rs1 with rs2, funct3 picks the condition later
`INSTR({7'h00, 3'h0, OpB     },  5, AluSub,   0, 0, 3'h0, 0, 0, 0, 0, 1, 0)  // BEQ
`INSTR({7'h00, 3'h1, OpB     },  6, AluSub,   0, 0, 3'h0, 0, 0, 0, 0, 1, 0)  // BNE
`INSTR({7'h00, 3'h4, OpB     },  7, AluSlt,   0, 0, 3'h0, 0, 0, 0, 0, 1, 0)  // BLT
`INSTR({7'h00, 3'h5, OpB     },  8, AluSlt,   0, 0, 3'h0, 0, 0, 0, 0, 1, 0)  // BGE
`INSTR({7'h00, 3'h6, OpB     },  9, AluSltu,  0, 0, 3'h0, 0, 0, 0, 0, 1, 0)  // BLTU
`INSTR({7'h00, 3'h7, OpB     }, 10, AluSltu,  0, 0, 3'h0, 0, 0, 0, 0, 1, 0)  // BGEU

// Loads and stores
`INSTR({7'h00, 3'h0, OpILoad }, 11, AluAdd,   0, 1, 3'h0, 1, 0, 1, 1, 0, 0)  // LB
`INSTR({7'h00, 3'h1, OpILoad }, 12, AluAdd,   0, 1, 3'h1, 1, 0, 1, 1, 0, 0)  // LH
`INSTR({7'h00, 3'h2, OpILoad }, 13, AluAdd,   0, 1, 3'h2, 1, 0, 1, 1, 0, 0)  // LW
`INSTR({7'h00, 3'h4, OpILoad }, 14, AluAdd,   0, 1, 3'h4, 1, 0, 1, 1, 0, 0)  // LBU
`INSTR({7'h00, 3'h5, OpILoad }, 15, AluAdd,   0, 1, 3'h5, 1, 0, 1, 1, 0, 0)  // LHU
`INSTR({7'h00, 3'h0, OpS     }, 16, AluAdd,   0, 1, 3'h0, 0, 1, 0, 0, 0, 0)  // SB
`INSTR({7'h00, 3'h1, OpS     }, 17, AluAdd,   0, 1, 3'h1, 0, 1, 0, 0, 0, 0)  // SH
`INSTR({7'h00, 3'h2, OpS     }, 18, AluAdd,   0, 1, 3'h2, 0, 1, 0, 0, 0, 0)  // SW

// Register-immediate
`INSTR({7'h00, 3'h0, OpIArith}, 19, AluAdd,   0, 1, 3'h0, 0, 0, 1, 0, 0, 0)  // ADDI
`INSTR({7'h00, 3'h2, OpIArith}, 20, AluSlt,   0, 1, 3'h0, 0, 0, 1, 0, 0, 0)  // SLTI
`INSTR({7'h00, 3'h3, OpIArith}, 21, AluSltu,  0, 1, 3'h0, 0, 0, 1, 0, 0, 0)  // SLTIU
`INSTR({7'h00, 3'h4, OpIArith}, 22, AluXor,   0, 1, 3'h0, 0, 0, 1, 0, 0, 0)  // XORI
`INSTR({7'h00, 3'h6, OpIArith}, 23, AluOr,    0, 1, 3'h0, 0, 0, 1, 0, 0, 0)  // ORI
`INSTR({7'h00, 3'h7, OpIArith}, 24, AluAnd,   0, 1, 3'h0, 0, 0, 1, 0, 0, 0)  // ANDI
`INSTR({7'h00, 3'h1, OpIArith}, 25, AluSll,   0, 1, 3'h0, 0, 0, 1, 0, 0, 0)  // SLLI
`INSTR({7'h00, 3'h5, OpIArith}, 26, AluSrl,   0, 1, 3'h0, 0, 0, 1, 0, 0, 0)  // SRLI
`INSTR({7'h20, 3'h5, OpIArith}, 27, AluSra,   0, 1, 3'h0, 0, 0, 1, 0, 0, 0)  // SRAI

// Register-register
`INSTR({7'h00, 3'h0, OpR     }, 28, AluAdd,   0, 0, 3'h0, 0, 0, 1, 0, 0, 0)  // ADD
`INSTR({7'h20, 3'h0, OpR     }, 29, AluSub,   0, 0, 3'h0, 0, 0, 1, 0, 0, 0)  // SUB
`INSTR({7'h00, 3'h1, OpR     }, 30, AluSll,   0, 0, 3'h0, 0, 0, 1, 0, 0, 0)  // SLL
`INSTR({7'h00, 3'h2, OpR     }, 31, AluSlt,   0, 0, 3'h0, 0, 0, 1, 0, 0, 0)  // SLT
`INSTR({7'h00, 3'h3, OpR     }, 32, AluSltu,  0, 0, 3'h0, 0, 0, 1, 0, 0, 0)  // SLTU
`INSTR({7'h00, 3'h4, OpR     }, 33, AluXor,   0, 0, 3'h0, 0, 0, 1, 0, 0, 0)  // XOR
`INSTR({7'h00, 3'h5, OpR     }, 34, AluSrl,   0, 0, 3'h0, 0, 0, 1, 0, 0, 0)  // SRL
`INSTR({7'h20, 3'h5, OpR     }, 35, AluSra,   0, 0, 3'h0, 0, 0, 1, 0, 0, 0)  // SRA
`INSTR({7'h00, 3'h6, OpR     }, 36, AluOr,    0, 0, 3'h0, 0, 0, 1, 0, 0, 0)  // OR
`INSTR({7'h00, 3'h7, OpR     }, 37, AluAnd,   0, 0, 3'h0, 0, 0, 1, 0, 0, 0)  // AND

// Fence and system carry no control
`INSTR({7'h00, 3'h0, OpIFence}, 38, AluNone,  0, 0, 3'h0, 0, 0, 0, 0, 0, 0)  // FENCE
`INSTR({7'h00, 3'h1, OpIFence}, 39, AluNone,  0, 0, 3'h0, 0, 0, 0, 0, 0, 0)  // FENCE.I
`INSTR({7'h00, 3'h0, OpISys  }, 40, AluNone,  0, 0, 3'h0, 0, 0, 0, 0, 0, 0)  // ECALL, EBREAK

// ==== verilog/rvDecodePkg.sv ====
package rvDecodePkg;

    // ============================================================
    // Instruction field positions
    // ============================================================
    localparam int OpcodeLsb = 0;
    localparam int RdLsb     = 7;
    localparam int Funct3Lsb = 12;
    localparam int Rs1Lsb    = 15;
    localparam int Rs2Lsb    = 20;
    localparam int Funct7Lsb = 25;

    // RV32I base opcodes
    localparam logic [6:0] OpR      = 7'b0110011;
    localparam logic [6:0] OpIArith = 7'b0010011;
    localparam logic [6:0] OpILoad  = 7'b0000011;
    localparam logic [6:0] OpIJump  = 7'b1100111;  // JALR
    localparam logic [6:0] OpIFence = 7'b0001111;
    localparam logic [6:0] OpISys   = 7'b1110011;
    localparam logic [6:0] OpS      = 7'b0100011;
    localparam logic [6:0] OpB      = 7'b1100011;
    localparam logic [6:0] OpLui    = 7'b0110111;
    localparam logic [6:0] OpAuipc  = 7'b0010111;
    localparam logic [6:0] OpJ      = 7'b1101111;  // JAL

    // ============================================================
    // ALU operation codes
    // ============================================================
    localparam logic [4:0] AluNone  = 5'd0;  // Empty control word
    localparam logic [4:0] AluAdd   = 5'd1;
    localparam logic [4:0] AluSub   = 5'd2;
    localparam logic [4:0] AluSll   = 5'd3;
    localparam logic [4:0] AluSlt   = 5'd4;
    localparam logic [4:0] AluSltu  = 5'd5;
    localparam logic [4:0] AluXor   = 5'd6;
    localparam logic [4:0] AluSrl   = 5'd7;
    localparam logic [4:0] AluSra   = 5'd8;
    localparam logic [4:0] AluOr    = 5'd9;
    localparam logic [4:0] AluAnd   = 5'd10;
    localparam logic [4:0] AluPassB = 5'd11;  // LUI result is the immediate

    // Decode table size, index 0 is kept for "no match"
    localparam int instrCount     = 40;
    localparam int instrAddrWidth = $clog2(instrCount + 1);

    // Which fields make up the match key
    typedef enum logic [1:0] {
        KeyOp,
        KeyF3Op,
        KeyF7F3Op
    } keySelT;

    // ============================================================
    // Stage payloads
    // ============================================================
    typedef struct packed {
        logic [4:0] aluOp;
        logic       aSel;      // 1 = PC
        logic       bSel;      // 1 = immediate
        logic [2:0] ldExt;     // funct3 style width and sign
        logic       memRead;
        logic       memWrite;
        logic       regWrite;
        logic       memToReg;
        logic       branch;
        logic       jump;
    } ctrlT;

    // Valid must stay the first field of each payload
    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] instr;
    } ifIdT;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] imm;
        logic [31:0] rs1Data;
        logic [31:0] rs2Data;
        logic [4:0]  rd;
        logic [2:0]  funct3;
        ctrlT        ctrl;
    } idExT;

    // Writeback request from the later stages
    typedef struct packed {
        logic        en;
        logic [4:0]  addr;
        logic [31:0] data;
    } wbT;

endpackage

// ==== verilog/ImmGen.sv ====
`timescale 1ns/100ps

module ImmGen import rvDecodePkg::*; (
    input  logic [31:0] instr,
    output logic [31:0] imm
);
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       isShamt;

    assign opcode  = instr[OpcodeLsb +: 7];
    assign funct3  = instr[Funct3Lsb +: 3];
    assign isShamt = !funct3[1] && funct3[0];  // SLLI, SRLI, SRAI

    always_comb begin
        case (opcode)
            OpILoad, OpIJump: begin
                imm = {{20{instr[31]}}, instr[31:20]};
            end
            OpIArith: begin
                // Shifts only use the low five bits, funct7 sits above them
                imm = isShamt ? {27'd0, instr[24:20]} : {{20{instr[31]}}, instr[31:20]};
            end
            OpS: begin
                imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            end
            OpB: begin
                imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            OpLui, OpAuipc: begin
                imm = {instr[31:12], 12'd0};
            end
            OpJ: begin
                imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            default: begin
                imm = '0;  // R type, fence, system, unknown
            end
        endcase
    end

endmodule

// ==== verilog/Controller.sv ====
`timescale 1ns/100ps

module Controller import rvDecodePkg::*; (
    input  logic [31:0] instr,
    output ctrlT        ctrl
);
    logic [6:0]                opcode;
    logic [2:0]                funct3;
    logic [6:0]                funct7;
    logic                      isShiftImm;
    keySelT                    keySel;
    logic [16:0]               key;
    logic [instrAddrWidth-1:0] instrIdx;

    assign opcode     = instr[OpcodeLsb +: 7];
    assign funct3     = instr[Funct3Lsb +: 3];
    assign funct7     = instr[Funct7Lsb +: 7];
    assign isShiftImm = !funct3[1] && funct3[0];

    // ============================================================
    // 1. Classify by the fields that identify the instruction
    // ============================================================
    always_comb begin
        case (opcode)
            OpR:                        keySel = KeyF7F3Op;
            OpIArith:                   keySel = isShiftImm ? KeyF7F3Op : KeyF3Op;
            OpILoad, OpIJump, OpIFence: keySel = KeyF3Op;
            OpISys, OpS, OpB:           keySel = KeyF3Op;
            OpLui, OpAuipc, OpJ:        keySel = KeyOp;
            default:                    keySel = KeyF7F3Op;  // Never matches
        endcase
    end

    // Unused fields of the key are forced to zero
    always_comb begin
        case (keySel)
            KeyOp:   key = {7'd0, 3'd0, opcode};
            KeyF3Op: key = {7'd0, funct3, opcode};
            default: key = {funct7, funct3, opcode};
        endcase
    end

    // ============================================================
    // 2. Key to table index
    // ============================================================
    always_comb begin
        case (key)
`define INSTR(KEY, IDX, ALU, A, B, LD, MR, MW, RW, M2R, BR, J) \
            KEY : instrIdx = instrAddrWidth'(IDX);
`include "instrTable.svh"
`undef INSTR
            default : instrIdx = '0;
        endcase
    end

    // ============================================================
    // 3. Table index to control word
    // ============================================================
    always_comb begin
        case (instrIdx)
`define INSTR(KEY, IDX, ALU, A, B, LD, MR, MW, RW, M2R, BR, J) \
            instrAddrWidth'(IDX) : ctrl = '{aluOp: ALU, aSel: 1'(A), bSel: 1'(B), \
                ldExt: LD, memRead: 1'(MR), memWrite: 1'(MW), regWrite: 1'(RW), \
                memToReg: 1'(M2R), branch: 1'(BR), jump: 1'(J)};
`include "instrTable.svh"
`undef INSTR
            default : ctrl = '0;  // Index 0, no match
        endcase
    end

endmodule

// ==== verilog/RegFile.sv ====
`timescale 1ns/100ps

module RegFile import rvDecodePkg::*; (
    input  logic        clk,
    input  logic        rstN,
    input  logic [4:0]  rs1Addr,
    input  logic [4:0]  rs2Addr,
    input  wbT          wb,
    output logic [31:0] rs1Data,
    output logic [31:0] rs2Data
);
    logic [31:0] regs [1:31];  // x0 has no storage

    // x0 first, then the bypass, then the array
    function automatic logic [31:0] readPort(input logic [4:0] addr);
        logic [31:0] value;
        if (addr == 5'd0) begin
            value = '0;
        end else if (wb.en && (wb.addr == addr)) begin
            value = wb.data;  // Written this cycle
        end else begin
            value = regs[addr];
        end
        return value;
    endfunction

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.en && (wb.addr != 5'd0)) begin
            regs[wb.addr] <= wb.data;
        end
    end

    always_comb begin
        rs1Data = readPort(rs1Addr);
    end

    always_comb begin
        rs2Data = readPort(rs2Addr);
    end

endmodule

// ==== verilog/StageReg.sv ====
`timescale 1ns/100ps

module StageReg #(
    parameter type payloadT = logic [31:0]
) (
    input  logic    clk,
    input  logic    rstN,
    input  logic    stall,
    input  logic    flush,
    input  payloadT d,
    output payloadT q
);

    // ============================================================
    // Payload register, valid is the top bit
    // ============================================================
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            q <= '0;
        end else if (flush) begin
            // Kill the slot even when stalled
            q[$bits(payloadT)-1] <= 1'b0;
        end else if (!stall) begin
            q <= d;
        end
    end

endmodule

// ==== verilog/DecodeStage.sv ====
`timescale 1ns/100ps

module DecodeStage import rvDecodePkg::*; (
    input  logic clk,
    input  logic rstN,
    input  ifIdT fetch,
    input  logic stall,
    input  logic flush,
    input  wbT   wb,
    output idExT decoded
);
    ifIdT        ifIdQ;
    idExT        idExD;
    logic [31:0] imm;
    logic [31:0] rs1Data;
    logic [31:0] rs2Data;
    ctrlT        ctrl;

    // ============================================================
    // IF/ID
    // ============================================================
    StageReg #(.payloadT(ifIdT)) i_IfIdReg (
        .clk   (clk),
        .rstN  (rstN),
        .stall (stall),
        .flush (flush),
        .d     (fetch),
        .q     (ifIdQ)
    );

    // Decode, all combinational from the IF/ID word
    ImmGen i_ImmGen (
        .instr (ifIdQ.instr),
        .imm   (imm)
    );

    Controller i_Controller (
        .instr (ifIdQ.instr),
        .ctrl  (ctrl)
    );

    RegFile i_RegFile (
        .clk     (clk),
        .rstN    (rstN),
        .rs1Addr (ifIdQ.instr[Rs1Lsb +: 5]),
        .rs2Addr (ifIdQ.instr[Rs2Lsb +: 5]),
        .wb      (wb),
        .rs1Data (rs1Data),
        .rs2Data (rs2Data)
    );

    assign idExD = '{
        valid:   ifIdQ.valid,
        pc:      ifIdQ.pc,
        imm:     imm,
        rs1Data: rs1Data,
        rs2Data: rs2Data,
        rd:      ifIdQ.instr[RdLsb +: 5],
        funct3:  ifIdQ.instr[Funct3Lsb +: 3],  // Branch condition and load width
        ctrl:    ctrl
    };

    // ============================================================
    // ID/EX
    // ============================================================
    StageReg #(.payloadT(idExT)) i_IdExReg (
        .clk   (clk),
        .rstN  (rstN),
        .stall (stall),
        .flush (flush),
        .d     (idExD),
        .q     (decoded)
    );

endmodule

// ==== sim/ClockGen.sv ====
`timescale 1ns/100ps

module ClockGen (
    output logic clk,
    output logic rstN
);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;  // 100 ns period
    end

    // Reset low over the first 8 rising edges
    initial begin
        rstN = 1'b0;
        repeat (8) @(posedge clk);
        #5 rstN = 1'b1;
    end

endmodule

// ==== sim/DecodeStage_sva.sv ====
`timescale 1ns/100ps

module StageRegSva #(
    parameter int width = 32
) (
    input logic             clk,
    input logic             rstN,
    input logic             stall,
    input logic             flush,
    input logic [width-1:0] q
);
    int failCount = 0;  // Read by the testbench at the end

    // Stall without flush freezes the whole payload
    holdOnStall: assert property (@(posedge clk) disable iff (!rstN)
        stall && !flush |=> $stable(q))
    else begin
        failCount++;
        $error("Stage register changed while stalled");
    end

    // Valid is the top bit of every payload
    flushKillsValid: assert property (@(posedge clk) disable iff (!rstN)
        flush |=> !q[width-1])
    else begin
        failCount++;
        $error("Stage register still valid after a flush");
    end

    resetClearsValid: assert property (@(posedge clk) $rose(rstN) |-> !q[width-1])
    else begin
        failCount++;
        $error("Stage register valid right after reset");
    end

endmodule

bind StageReg StageRegSva #(.width($bits(payloadT))) i_StageRegSva (
    .clk   (clk),
    .rstN  (rstN),
    .stall (stall),
    .flush (flush),
    .q     (q)
);

// ==== sim/DecodeStageTb.sv ====
`timescale 1ns/100ps

module DecodeStageTb import rvDecodePkg::*; ();
    logic clk;
    logic rstN;
    ifIdT fetch;
    logic stall;
    logic flush;
    wbT   wb;
    idExT decoded;
    int   seed = 91179;
    int   cycleCount = 0;

    ClockGen i_ClockGen (
        .clk  (clk),
        .rstN (rstN)
    );

    DecodeStage i_DecodeStage (
        .clk     (clk),
        .rstN    (rstN),
        .fetch   (fetch),
        .stall   (stall),
        .flush   (flush),
        .wb      (wb),
        .decoded (decoded)
    );

    // ============================================================
    // Error handling and compare tasks
    // ============================================================
    task automatic stopOnError(input string msg);
        $display("%s", msg);
        $display("Test FAILED");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    task automatic checkCtrl(input string what, input ctrlT got, input ctrlT exp);
        if (got !== exp) begin
            stopOnError($sformatf("CHECK FAILED at %0t ns: %s is %h, expected %h",
                $time, what, got, exp));
        end
    endtask

    task automatic checkWord(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
        if (got !== exp) begin
            stopOnError($sformatf("CHECK FAILED at %0t ns: %s is %h, expected %h",
                $time, what, got, exp));
        end
    endtask

    task automatic checkValid(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            stopOnError($sformatf("CHECK FAILED at %0t ns: %s is %b, expected %b",
                $time, what, got, exp));
        end
    endtask

    // Limit well above the roughly 90 cycles the tests need
    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= 400) begin
            stopOnError("Timeout: the tests did not finish within 400 clock cycles");
        end
    end

    // ============================================================
    // Instruction words from their fields
    // ============================================================
    function automatic logic [31:0] rTypeWord(input logic [6:0] f7, input logic [4:0] rs2,
        input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OpR};
    endfunction

    function automatic logic [31:0] iTypeWord(input logic [11:0] imm, input logic [4:0] rs1,
        input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] sTypeWord(input logic [11:0] imm, input logic [4:0] rs2,
        input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], OpS};
    endfunction

    function automatic logic [31:0] bTypeWord(input logic [12:0] imm, input logic [2:0] f3);
        return {imm[12], imm[10:5], 5'd2, 5'd1, f3, imm[4:1], imm[11], OpB};
    endfunction

    function automatic logic [31:0] uTypeWord(input logic [19:0] imm, input logic [6:0] op);
        return {imm, 5'd3, op};
    endfunction

    function automatic logic [31:0] jTypeWord(input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd1, OpJ};
    endfunction

    // Flags are memRead, memWrite, regWrite, memToReg, branch, jump
    function automatic ctrlT ctrlWord(input logic [4:0] alu, input logic a, input logic b,
        input logic [2:0] ld, input logic [5:0] flags);
        return {alu, a, b, ld, flags};
    endfunction

    // ============================================================
    // Stimulus helpers
    // ============================================================
    task automatic tick();
        @(posedge clk);
        #5;
    endtask

    task automatic issueFetch(input logic [31:0] instr, input logic [31:0] pc);
        fetch = '{valid: 1'b1, pc: pc, instr: instr};
    endtask

    // One instruction through both stages, fixed two-cycle latency
    task automatic decodeOne(input logic [31:0] instr, input logic [31:0] pc);
        issueFetch(instr, pc);
        tick();
        fetch.valid = 1'b0;
        tick();
        checkValid("decoded.valid", decoded.valid, 1'b1);
        checkWord("decoded.pc", decoded.pc, pc);
    endtask

    task automatic controlCase(input logic [31:0] instr, input ctrlT exp);
        decodeOne(instr, 32'h200);
        checkCtrl("decoded.ctrl", decoded.ctrl, exp);
    endtask

    // ============================================================
    // Directed tests
    // ============================================================
    task automatic immediateFormats();
        logic [31:0] r;
        logic [11:0] i12;
        logic [12:0] b13;
        logic [20:0] j21;
        for (int n = 0; n < 2; n++) begin
            r   = $random(seed);
            i12 = r[11:0];
            decodeOne(iTypeWord(i12, 5'd1, 3'd0, 5'd2, OpIArith), 32'h100);
            checkWord("I imm", decoded.imm, {{20{i12[11]}}, i12});
            decodeOne(iTypeWord({7'h20, r[16:12]}, 5'd1, 3'd5, 5'd2, OpIArith), 32'h104);
            checkWord("SRAI shamt", decoded.imm, {27'd0, r[16:12]});
            checkWord("decoded.rd", 32'(decoded.rd), 32'd2);
            checkWord("decoded.funct3", 32'(decoded.funct3), 32'd5);
            decodeOne(iTypeWord({7'h00, r[21:17]}, 5'd1, 3'd1, 5'd2, OpIArith), 32'h108);
            checkWord("SLLI shamt", decoded.imm, {27'd0, r[21:17]});
            r   = $random(seed);
            i12 = r[11:0];
            decodeOne(sTypeWord(i12, 5'd3, 5'd1, 3'd2), 32'h10c);
            checkWord("S imm", decoded.imm, {{20{i12[11]}}, i12});
            checkWord("decoded.funct3", 32'(decoded.funct3), 32'd2);
            r   = $random(seed);
            b13 = {r[12:1], 1'b0};
            decodeOne(bTypeWord(b13, 3'd0), 32'h110);
            checkWord("B imm", decoded.imm, {{19{b13[12]}}, b13});
            r = $random(seed);
            decodeOne(uTypeWord(r[31:12], OpLui), 32'h114);
            checkWord("U imm", decoded.imm, {r[31:12], 12'd0});
            r   = $random(seed);
            j21 = {r[20:1], 1'b0};
            decodeOne(jTypeWord(j21), 32'h118);
            checkWord("J imm", decoded.imm, {{11{j21[20]}}, j21});
            checkWord("decoded.rd", 32'(decoded.rd), 32'd1);
        end
    endtask

    task automatic controlWords();
        controlCase(rTypeWord(7'h00, 5'd2, 5'd1, 3'd0, 5'd3), ctrlWord(AluAdd, 0, 0, 0, 6'b001000));
        controlCase(rTypeWord(7'h20, 5'd2, 5'd1, 3'd0, 5'd3), ctrlWord(AluSub, 0, 0, 0, 6'b001000));
        controlCase(rTypeWord(7'h20, 5'd2, 5'd1, 3'd5, 5'd3), ctrlWord(AluSra, 0, 0, 0, 6'b001000));
        controlCase(iTypeWord(12'h123, 5'd1, 3'd0, 5'd3, OpIArith),
            ctrlWord(AluAdd, 0, 1, 0, 6'b001000));
        controlCase(iTypeWord(12'h404, 5'd1, 3'd5, 5'd3, OpIArith),
            ctrlWord(AluSra, 0, 1, 0, 6'b001000));
        controlCase(iTypeWord(12'h010, 5'd1, 3'd2, 5'd3, OpILoad),
            ctrlWord(AluAdd, 0, 1, 3'h2, 6'b101100));
        controlCase(iTypeWord(12'h011, 5'd1, 3'd4, 5'd3, OpILoad),
            ctrlWord(AluAdd, 0, 1, 3'h4, 6'b101100));
        controlCase(sTypeWord(12'h020, 5'd2, 5'd1, 3'd2), ctrlWord(AluAdd, 0, 1, 3'h2, 6'b010000));
        controlCase(bTypeWord(13'h008, 3'd0), ctrlWord(AluSub, 0, 0, 0, 6'b000010));
        controlCase(uTypeWord(20'h12345, OpLui), ctrlWord(AluPassB, 0, 1, 0, 6'b001000));
        controlCase(uTypeWord(20'h12345, OpAuipc), ctrlWord(AluAdd, 1, 1, 0, 6'b001000));
        controlCase(jTypeWord(21'h000800), ctrlWord(AluAdd, 1, 1, 0, 6'b001001));
        controlCase(iTypeWord(12'h004, 5'd1, 3'd0, 5'd1, OpIJump),
            ctrlWord(AluAdd, 0, 1, 0, 6'b001001));
        controlCase(32'hffff_ffff, '0);  // Opcode 1111111 is not RV32I
        controlCase(iTypeWord(12'h0ff, 5'd0, 3'd0, 5'd0, OpIFence), '0);
    endtask

    task automatic registerAccess();
        logic [31:0] data;
        logic [31:0] bypassData;
        data       = $random(seed);
        bypassData = $random(seed);
        wb = '{en: 1'b1, addr: 5'd5, data: data};
        tick();
        wb.en = 1'b0;
        decodeOne(rTypeWord(7'h00, 5'd6, 5'd5, 3'd0, 5'd1), 32'h300);  // ADD x1, x5, x6
        checkWord("rs1Data x5", decoded.rs1Data, data);
        checkWord("rs2Data x6", decoded.rs2Data, 32'd0);
        wb = '{en: 1'b1, addr: 5'd0, data: data};
        tick();
        wb.en = 1'b0;
        decodeOne(rTypeWord(7'h00, 5'd5, 5'd0, 3'd0, 5'd1), 32'h304);
        checkWord("rs1Data x0", decoded.rs1Data, 32'd0);
        // Write x7 while the reading instruction sits in IF/ID
        issueFetch(rTypeWord(7'h00, 5'd7, 5'd0, 3'd0, 5'd1), 32'h308);
        tick();
        fetch.valid = 1'b0;
        wb = '{en: 1'b1, addr: 5'd7, data: bypassData};
        tick();
        wb.en = 1'b0;
        checkWord("rs2Data bypass", decoded.rs2Data, bypassData);
        checkWord("rs1Data x0", decoded.rs1Data, 32'd0);
    endtask

    task automatic streamAndStall();
        for (int n = 0; n < 4; n++) begin
            issueFetch(iTypeWord(12'(n), 5'd0, 3'd0, 5'(n + 1), OpIArith), 32'h400 + 32'(4 * n));
            if (n >= 2) begin
                checkValid("stream valid", decoded.valid, 1'b1);
                checkWord("stream pc", decoded.pc, 32'h400 + 32'(4 * (n - 2)));
            end
            tick();
        end
        stall = 1'b1;
        issueFetch(iTypeWord(12'd4, 5'd0, 3'd0, 5'd5, OpIArith), 32'h410);  // Held by source
        checkWord("stall pc", decoded.pc, 32'h408);
        repeat (3) begin
            tick();
            checkValid("stall valid", decoded.valid, 1'b1);
            checkWord("stall pc", decoded.pc, 32'h408);
        end
        stall = 1'b0;
        tick();
        fetch.valid = 1'b0;
        checkWord("resume pc", decoded.pc, 32'h40c);
        tick();
        checkValid("resume valid", decoded.valid, 1'b1);
        checkWord("resume pc", decoded.pc, 32'h410);
    endtask

    task automatic flushSlot();
        issueFetch(iTypeWord(12'h7ff, 5'd0, 3'd0, 5'd10, OpIArith), 32'h500);
        tick();
        fetch.valid = 1'b0;
        flush = 1'b1;
        tick();
        flush = 1'b0;
        checkValid("flushed slot valid", decoded.valid, 1'b0);
        issueFetch(iTypeWord(12'h001, 5'd0, 3'd0, 5'd11, OpIArith), 32'h504);
        tick();
        fetch.valid = 1'b0;
        checkValid("flushed slot valid", decoded.valid, 1'b0);
        tick();
        checkValid("after flush valid", decoded.valid, 1'b1);
        checkWord("after flush pc", decoded.pc, 32'h504);
    endtask

    // ============================================================
    // Main sequence
    // ============================================================
    initial begin
        fetch = '0;
        stall = 1'b0;
        flush = 1'b0;
        wb    = '0;
        // A valid word offered during reset must not get through
        issueFetch(rTypeWord(7'h00, 5'd2, 5'd1, 3'd0, 5'd3), 32'h80);
        @(posedge rstN);
        checkValid("reset valid", decoded.valid, 1'b0);
        checkCtrl("reset ctrl", decoded.ctrl, '0);
        fetch.valid = 1'b0;
        tick();
        immediateFormats();
        controlWords();
        registerAccess();
        streamAndStall();
        flushSlot();
        tick();
        if (i_DecodeStage.i_IfIdReg.i_StageRegSva.failCount
            + i_DecodeStage.i_IdExReg.i_StageRegSva.failCount == 0) begin
            $display("Test OK");
            $finish;
        end else begin
            stopOnError("Stage register assertions reported failures");
        end
    end

endmodule

// ==== DecodeStage.f ====
+incdir+verilog
verilog/rvDecodePkg.sv
verilog/ImmGen.sv
verilog/Controller.sv
verilog/RegFile.sv
verilog/StageReg.sv
verilog/DecodeStage.sv
sim/ClockGen.sv
sim/DecodeStage_sva.sv
sim/DecodeStageTb.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = DecodeStageTb
FILELIST  = DecodeStage.f
OBJDIR    = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Test OK$$"

clean:
	rm -rf $(OBJDIR)
